// File: verilog/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// Data and address width of the core.
`define XLEN 32

// The data memory holds 2**DMEM_AW words.
`define DMEM_AW 8

`endif

// File: verilog/rv32i_types.sv
`include "rv32i_defs.svh"

package rv32i_types;

    typedef logic [`XLEN-1:0]   word_t;      // Data or address word.
    typedef logic [4:0]         reg_idx_t;   // Architectural register index.
    typedef logic [`XLEN/8-1:0] byte_mask_t; // One bit per byte lane.

    // Width codes as they appear in funct3 of loads and stores.
    // Stores only use the signed codes.
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_funct3_t;

endpackage

// File: verilog/pipe_types.sv
package pipe_types;

    // Source of the value written back to the register file.
    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        pc_plus4_wb = 4'd3,
        lw_wb       = 4'd4,
        lb_wb       = 4'd5,
        lbu_wb      = 4'd6,
        lh_wb       = 4'd7,
        lhu_wb      = 4'd8
    } wb_sel_t;

    typedef logic [63:0] order_t; // Retirement order of an instruction.

endpackage

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  rv32i_types::word_t       in_pc,
    input  pipe_types::order_t       in_order,
    input  rv32i_types::reg_idx_t    in_rd_s,
    input  logic                     in_regf_we,
    input  pipe_types::wb_sel_t      in_wb_sel,
    input  rv32i_types::word_t       in_alu_out,
    input  rv32i_types::word_t       in_br_en,
    input  rv32i_types::word_t       in_u_imm,
    input  rv32i_types::word_t       in_rs2_v,
    input  rv32i_types::mem_funct3_t in_funct3,
    input  logic                     in_mem_read,
    input  logic                     in_mem_write,
    output rv32i_types::word_t       dmem_addr,
    output rv32i_types::byte_mask_t  dmem_wmask,
    output rv32i_types::word_t       dmem_wdata,
    output logic                     dmem_re,
    output logic                     r_valid,
    output rv32i_types::word_t       r_pc,
    output pipe_types::order_t       r_order,
    output rv32i_types::reg_idx_t    r_rd_s,
    output logic                     r_regf_we,
    output pipe_types::wb_sel_t      r_wb_sel,
    output rv32i_types::word_t       r_alu_out,
    output rv32i_types::word_t       r_br_en,
    output rv32i_types::word_t       r_u_imm,
    output logic [1:0]               r_offset,
    output rv32i_types::mem_funct3_t r_funct3,
    output logic                     r_misaligned
);

    logic [1:0]              offset;
    logic                    mem_access;
    logic                    misaligned;
    rv32i_types::byte_mask_t lane_mask;

    assign offset     = in_alu_out[1:0];
    assign mem_access = in_valid && (in_mem_read || in_mem_write);

    // Lanes touched by the access and whether the offset fits its width.
    always_comb begin
        case (in_funct3)
            rv32i_types::mem_h, rv32i_types::mem_hu: begin
                lane_mask  = rv32i_types::byte_mask_t'(3) << offset;
                misaligned = offset[0];
            end
            rv32i_types::mem_w: begin
                lane_mask  = '1;
                misaligned = (offset != 2'd0);
            end
            default: begin
                lane_mask  = rv32i_types::byte_mask_t'(1) << offset;
                misaligned = 1'b0;
            end
        endcase
    end

    assign dmem_addr  = {in_alu_out[31:2], 2'b00}; // Memory works on whole words.
    assign dmem_wdata = in_rs2_v << {offset, 3'b000};
    assign dmem_wmask = (in_valid && in_mem_write && !misaligned) ? lane_mask : '0;
    assign dmem_re    = in_valid && in_mem_read && !misaligned;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid      <= 1'b0;
            r_regf_we    <= 1'b0;
            r_misaligned <= 1'b0;
            r_pc         <= '0;
        end else begin
            r_valid      <= in_valid;
            r_regf_we    <= in_regf_we;
            r_misaligned <= mem_access && misaligned; // Flag follows its instruction.
            r_pc         <= in_pc;
        end
    end

    always_ff @(posedge clk) begin
        r_order   <= in_order;
        r_rd_s    <= in_rd_s;
        r_wb_sel  <= in_wb_sel;
        r_alu_out <= in_alu_out;
        r_br_en   <= in_br_en;
        r_u_imm   <= in_u_imm;
        r_offset  <= offset;
        r_funct3  <= in_funct3;
    end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module data_mem (
    input  logic                    clk,
    input  rv32i_types::word_t      addr,
    input  rv32i_types::byte_mask_t wmask,
    input  rv32i_types::word_t      wdata,
    input  logic                    re,
    output rv32i_types::word_t      rdata
);

    localparam int DEPTH = 1 << `DMEM_AW;
    localparam int LANES = $bits(rv32i_types::byte_mask_t);

    rv32i_types::word_t   mem [DEPTH];
    logic [`DMEM_AW-1:0]  idx;

    // Word index, upper address bits wrap around the array.
    assign idx = addr[`DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wmask[i]) begin
                mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
        if (re) begin
            rdata <= mem[idx]; // Holds the last word when no read is requested.
        end
    end

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  rv32i_types::word_t rdata,
    input  logic [1:0]         offset,
    output rv32i_types::word_t lw,
    output rv32i_types::word_t lb,
    output rv32i_types::word_t lbu,
    output rv32i_types::word_t lh,
    output rv32i_types::word_t lhu
);

    rv32i_types::word_t shifted;
    logic [7:0]         load_byte;
    logic [15:0]        load_half;

    assign shifted   = rdata >> {offset, 3'b000};
    assign load_byte = shifted[7:0];
    assign load_half = offset[1] ? rdata[31:16] : rdata[15:0]; // offset[0] is zero when aligned

    assign lw  = rdata;
    assign lb  = {{24{load_byte[7]}}, load_byte};
    assign lbu = {24'd0, load_byte};
    assign lh  = {{16{load_half[15]}}, load_half};
    assign lhu = {16'd0, load_half};

endmodule

// File: verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                  r_valid,
    input  rv32i_types::word_t    r_pc,
    input  rv32i_types::reg_idx_t r_rd_s,
    input  logic                  r_regf_we,
    input  pipe_types::wb_sel_t   r_wb_sel,
    input  rv32i_types::word_t    r_alu_out,
    input  rv32i_types::word_t    r_br_en,
    input  rv32i_types::word_t    r_u_imm,
    input  logic                  r_misaligned,
    input  rv32i_types::word_t    lw,
    input  rv32i_types::word_t    lb,
    input  rv32i_types::word_t    lbu,
    input  rv32i_types::word_t    lh,
    input  rv32i_types::word_t    lhu,
    output logic                  wb_valid,
    output rv32i_types::reg_idx_t wb_rd_s,
    output rv32i_types::word_t    wb_rd_v,
    output logic                  wb_regf_we
);

    rv32i_types::word_t rd_v_sel;

    always_comb begin
        case (r_wb_sel)
            pipe_types::alu_out_wb:  rd_v_sel = r_alu_out;
            pipe_types::br_en_wb:    rd_v_sel = r_br_en;
            pipe_types::u_imm_wb:    rd_v_sel = r_u_imm;
            pipe_types::pc_plus4_wb: rd_v_sel = r_pc + 32'd4; // Link value of jal and jalr.
            pipe_types::lw_wb:       rd_v_sel = lw;
            pipe_types::lb_wb:       rd_v_sel = lb;
            pipe_types::lbu_wb:      rd_v_sel = lbu;
            pipe_types::lh_wb:       rd_v_sel = lh;
            pipe_types::lhu_wb:      rd_v_sel = lhu;
            default:                 rd_v_sel = '0;
        endcase
    end

    assign wb_valid   = r_valid;
    assign wb_rd_s    = r_rd_s;
    assign wb_rd_v    = r_valid ? rd_v_sel : '0;
    // x0 is never written, and a misaligned access retires without a result.
    assign wb_regf_we = r_valid && r_regf_we && (r_rd_s != '0) && !r_misaligned;

endmodule

// File: verilog/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  rv32i_types::word_t       in_pc,
    input  pipe_types::order_t       in_order,
    input  rv32i_types::reg_idx_t    in_rd_s,
    input  logic                     in_regf_we,
    input  pipe_types::wb_sel_t      in_wb_sel,
    input  rv32i_types::word_t       in_alu_out,
    input  rv32i_types::word_t       in_br_en,
    input  rv32i_types::word_t       in_u_imm,
    input  rv32i_types::word_t       in_rs2_v,
    input  rv32i_types::mem_funct3_t in_funct3,
    input  logic                     in_mem_read,
    input  logic                     in_mem_write,
    output logic                     wb_valid,
    output rv32i_types::reg_idx_t    wb_rd_s,
    output rv32i_types::word_t       wb_rd_v,
    output logic                     wb_regf_we,
    output pipe_types::order_t       wb_order,
    output logic                     wb_misaligned
);

    rv32i_types::word_t      dmem_addr;
    rv32i_types::byte_mask_t dmem_wmask;
    rv32i_types::word_t      dmem_wdata;
    logic                    dmem_re;
    rv32i_types::word_t      dmem_rdata;

    logic                    r_valid;
    rv32i_types::word_t      r_pc;
    rv32i_types::reg_idx_t   r_rd_s;
    logic                    r_regf_we;
    pipe_types::wb_sel_t     r_wb_sel;
    rv32i_types::word_t      r_alu_out;
    rv32i_types::word_t      r_br_en;
    rv32i_types::word_t      r_u_imm;
    logic [1:0]              r_offset;

    rv32i_types::word_t      lw;
    rv32i_types::word_t      lb;
    rv32i_types::word_t      lbu;
    rv32i_types::word_t      lh;
    rv32i_types::word_t      lhu;

    mem_stage u_mem_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_pc        (in_pc),
        .in_order     (in_order),
        .in_rd_s      (in_rd_s),
        .in_regf_we   (in_regf_we),
        .in_wb_sel    (in_wb_sel),
        .in_alu_out   (in_alu_out),
        .in_br_en     (in_br_en),
        .in_u_imm     (in_u_imm),
        .in_rs2_v     (in_rs2_v),
        .in_funct3    (in_funct3),
        .in_mem_read  (in_mem_read),
        .in_mem_write (in_mem_write),
        .dmem_addr    (dmem_addr),
        .dmem_wmask   (dmem_wmask),
        .dmem_wdata   (dmem_wdata),
        .dmem_re      (dmem_re),
        .r_valid      (r_valid),
        .r_pc         (r_pc),
        .r_order      (wb_order),
        .r_rd_s       (r_rd_s),
        .r_regf_we    (r_regf_we),
        .r_wb_sel     (r_wb_sel),
        .r_alu_out    (r_alu_out),
        .r_br_en      (r_br_en),
        .r_u_imm      (r_u_imm),
        .r_offset     (r_offset),
        .r_funct3     (),          // The load form is already encoded in wb_sel.
        .r_misaligned (wb_misaligned)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .addr  (dmem_addr),
        .wmask (dmem_wmask),
        .wdata (dmem_wdata),
        .re    (dmem_re),
        .rdata (dmem_rdata)
    );

    load_align u_load_align (
        .rdata  (dmem_rdata),
        .offset (r_offset),
        .lw     (lw),
        .lb     (lb),
        .lbu    (lbu),
        .lh     (lh),
        .lhu    (lhu)
    );

    wb_stage u_wb_stage (
        .r_valid      (r_valid),
        .r_pc         (r_pc),
        .r_rd_s       (r_rd_s),
        .r_regf_we    (r_regf_we),
        .r_wb_sel     (r_wb_sel),
        .r_alu_out    (r_alu_out),
        .r_br_en      (r_br_en),
        .r_u_imm      (r_u_imm),
        .r_misaligned (wb_misaligned),
        .lw           (lw),
        .lb           (lb),
        .lbu          (lbu),
        .lh           (lh),
        .lhu          (lhu),
        .wb_valid     (wb_valid),
        .wb_rd_s      (wb_rd_s),
        .wb_rd_v      (wb_rd_v),
        .wb_regf_we   (wb_regf_we)
    );

endmodule

// File: verification/mem_wb_assertions.sv
`timescale 1ns/1ps

module mem_wb_assertions (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    in_valid,
    input logic                    in_mem_write,
    input rv32i_types::byte_mask_t dmem_wmask,
    input logic                    wb_valid,
    input logic                    wb_regf_we,
    input rv32i_types::reg_idx_t   wb_rd_s,
    input logic                    wb_misaligned
);

    int fail_count = 0; // Failed assertions so far.

    we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        wb_regf_we |-> wb_valid)
        else begin
            fail_count++;
            $error("Register write without a valid instruction.");
        end

    // x0 is hardwired to zero.
    we_not_x0: assert property (@(posedge clk) disable iff (!arst_n)
        wb_regf_we |-> (wb_rd_s != 5'd0))
        else begin
            fail_count++;
            $error("Register write to x0.");
        end

    misaligned_no_we: assert property (@(posedge clk) disable iff (!arst_n)
        wb_misaligned |-> !wb_regf_we)
        else begin
            fail_count++;
            $error("Misaligned access wrote the register file.");
        end

    wmask_needs_store: assert property (@(posedge clk) disable iff (!arst_n)
        !(in_valid && in_mem_write) |-> (dmem_wmask == '0))
        else begin
            fail_count++;
            $error("Memory write mask set without a store.");
        end

endmodule

// File: verification/mem_wb_tb.sv
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module mem_wb_tb;

    localparam int TIMEOUT_CYCLES = 2000; // All tests together take about 120 cycles.

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     in_valid;
    rv32i_types::word_t       in_pc;
    pipe_types::order_t       in_order;
    rv32i_types::reg_idx_t    in_rd_s;
    logic                     in_regf_we;
    pipe_types::wb_sel_t      in_wb_sel;
    rv32i_types::word_t       in_alu_out;
    rv32i_types::word_t       in_br_en;
    rv32i_types::word_t       in_u_imm;
    rv32i_types::word_t       in_rs2_v;
    rv32i_types::mem_funct3_t in_funct3;
    logic                     in_mem_read;
    logic                     in_mem_write;
    logic                     wb_valid;
    rv32i_types::reg_idx_t    wb_rd_s;
    rv32i_types::word_t       wb_rd_v;
    logic                     wb_regf_we;
    pipe_types::order_t       wb_order;
    logic                     wb_misaligned;

    rv32i_types::word_t    ref_mem [int]; // Expected memory contents by word index.
    logic                  exp_valid;
    logic                  exp_we;
    logic                  exp_mis;
    rv32i_types::reg_idx_t exp_rd;
    rv32i_types::word_t    exp_rd_v;
    pipe_types::order_t    exp_order;
    int                    err_count = 0;
    int                    check_count = 0;
    int                    cycle_count = 0;

    mem_wb_top UUT (.*);

    bind mem_wb_top mem_wb_assertions u_assertions (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_mem_write  (in_mem_write),
        .dmem_wmask    (dmem_wmask),
        .wb_valid      (wb_valid),
        .wb_regf_we    (wb_regf_we),
        .wb_rd_s       (wb_rd_s),
        .wb_misaligned (wb_misaligned)
    );

    always #20 clk = ~clk;

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not complete.", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    task automatic record_check(input string name, input bit ok, input logic [63:0] exp,
                                input logic [63:0] act);
        check_count++;
        if (!ok) begin
            err_count++;
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input rv32i_types::word_t exp,
                              input rv32i_types::word_t act);
        record_check(name, act === exp, 64'(exp), 64'(act));
    endtask

    task automatic check_reg(input string name, input rv32i_types::reg_idx_t exp,
                             input rv32i_types::reg_idx_t act);
        record_check(name, act === exp, 64'(exp), 64'(act));
    endtask

    task automatic check_order(input string name, input pipe_types::order_t exp,
                               input pipe_types::order_t act);
        record_check(name, act === exp, exp, act);
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        record_check(name, act === exp, 64'(exp), 64'(act));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2; // Inputs change shortly after the edge.
    endtask

    function automatic rv32i_types::reg_idx_t rand_rd();
        return 5'($urandom % 31 + 1);
    endfunction

    // Random address inside the memory, aligned to an access of size bytes.
    function automatic rv32i_types::word_t rand_addr(input int size);
        return 32'((($urandom % (1 << `DMEM_AW)) << 2) + ($urandom % (4 / size)) * size);
    endfunction

    function automatic rv32i_types::mem_funct3_t load_width(input pipe_types::wb_sel_t sel);
        case (sel)
            pipe_types::lb_wb:  return rv32i_types::mem_b;
            pipe_types::lbu_wb: return rv32i_types::mem_bu;
            pipe_types::lh_wb:  return rv32i_types::mem_h;
            pipe_types::lhu_wb: return rv32i_types::mem_hu;
            default:            return rv32i_types::mem_w;
        endcase
    endfunction

    // Drives one instruction and works out its writeback from the RV32I rules.
    task automatic drive_instr(input pipe_types::wb_sel_t sel, input rv32i_types::reg_idx_t rd,
                               input rv32i_types::word_t alu, input rv32i_types::word_t data,
                               input rv32i_types::mem_funct3_t f3, input logic rd_en,
                               input logic wr_en);
        int                 idx;
        int                 off;
        int                 size;
        rv32i_types::word_t word;
        idx  = int'(alu[`DMEM_AW+1:2]);
        off  = int'(alu[1:0]);
        case (f3)
            rv32i_types::mem_w:                      size = 4;
            rv32i_types::mem_h, rv32i_types::mem_hu: size = 2;
            default:                                 size = 1;
        endcase
        word         = ref_mem.exists(idx) ? ref_mem[idx] : '0;
        in_valid     = 1'b1;
        in_pc        = $urandom & ~32'd3;
        in_order     = exp_order + 64'd1;
        in_rd_s      = rd;
        in_regf_we   = !wr_en;
        in_wb_sel    = sel;
        in_alu_out   = alu;
        in_br_en     = $urandom % 2;
        in_u_imm     = $urandom & 32'hffff_f000;
        in_rs2_v     = data;
        in_funct3    = f3;
        in_mem_read  = rd_en;
        in_mem_write = wr_en;
        exp_order    = in_order;
        exp_valid    = 1'b1;
        exp_rd       = rd;
        exp_mis      = (rd_en || wr_en) && (off % size != 0);
        exp_we       = !wr_en && (rd != 5'd0) && !exp_mis;
        if (wr_en && !exp_mis) begin
            for (int i = 0; i < size; i++) begin
                word[(off + i) * 8 +: 8] = data[i * 8 +: 8];
            end
            ref_mem[idx] = word;
        end
        case (sel)
            pipe_types::alu_out_wb:  exp_rd_v = alu;
            pipe_types::br_en_wb:    exp_rd_v = in_br_en;
            pipe_types::u_imm_wb:    exp_rd_v = in_u_imm;
            pipe_types::pc_plus4_wb: exp_rd_v = in_pc + 32'd4;
            pipe_types::lw_wb:       exp_rd_v = word;
            pipe_types::lb_wb:       exp_rd_v = 32'($signed(word[off * 8 +: 8]));
            pipe_types::lbu_wb:      exp_rd_v = 32'(word[off * 8 +: 8]);
            pipe_types::lh_wb:       exp_rd_v = 32'($signed(word[off * 8 +: 16]));
            default:                 exp_rd_v = 32'(word[off * 8 +: 16]);
        endcase
    endtask

    task automatic store(input rv32i_types::word_t addr, input rv32i_types::word_t data,
                         input rv32i_types::mem_funct3_t f3);
        drive_instr(pipe_types::alu_out_wb, rand_rd(), addr, data, f3, 1'b0, 1'b1);
    endtask

    task automatic load(input pipe_types::wb_sel_t sel, input rv32i_types::word_t addr);
        drive_instr(sel, rand_rd(), addr, '0, load_width(sel), 1'b1, 1'b0);
    endtask

    task automatic non_mem(input rv32i_types::reg_idx_t rd);
        drive_instr(pipe_types::wb_sel_t'($urandom % 4), rd, $urandom, '0,
                    rv32i_types::mem_w, 1'b0, 1'b0);
    endtask

    task automatic idle();
        in_valid     = 1'b0;
        in_mem_read  = 1'b0;
        in_mem_write = 1'b0;
        exp_valid    = 1'b0;
    endtask

    task automatic check_result(input string name);
        check_flag({name, " valid"}, exp_valid, wb_valid);
        if (exp_valid) begin
            check_order({name, " order"}, exp_order, wb_order);
            check_reg({name, " rd"}, exp_rd, wb_rd_s);
            check_flag({name, " misaligned"}, exp_mis, wb_misaligned);
            check_flag({name, " regf_we"}, exp_we, wb_regf_we);
            if (!exp_mis) begin
                check_word({name, " rd_v"}, exp_rd_v, wb_rd_v);
            end
        end else begin
            check_flag({name, " regf_we"}, 1'b0, wb_regf_we);
            check_flag({name, " misaligned"}, 1'b0, wb_misaligned);
            check_word({name, " rd_v"}, '0, wb_rd_v);
        end
    endtask

    // The result of the instruction on the inputs shows up one cycle later.
    task automatic retire(input string name);
        next_cycle();
        check_result(name);
    endtask

    task automatic check_reset_outputs(input string name);
        check_flag({name, " valid"}, 1'b0, wb_valid);
        check_flag({name, " regf_we"}, 1'b0, wb_regf_we);
        check_flag({name, " misaligned"}, 1'b0, wb_misaligned);
    endtask

    task automatic report_test(input string name, input int start);
        $display("Test %s finished with %0d mismatches", name, err_count - start);
    endtask

    task automatic test_non_mem();
        int start = err_count;
        for (int i = 0; i < 16; i++) begin
            non_mem((i % 4 == 3) ? 5'd0 : rand_rd()); // Every fourth one targets x0.
            retire("non_mem");
        end
        idle();
        retire("non_mem idle");
        report_test("non_mem", start);
    endtask

    task automatic test_word_store_load();
        int                 start = err_count;
        rv32i_types::word_t addr;
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr(4);
            store(addr, $urandom, rv32i_types::mem_w);
            retire("sw");
            load(pipe_types::lw_wb, addr);
            retire("lw after sw");
        end
        idle();
        retire("word idle");
        report_test("word_store_load", start);
    endtask

    task automatic test_sub_word();
        int                 start = err_count;
        rv32i_types::word_t base;
        base = rand_addr(4);
        store(base, 32'h8c3e_71a5, rv32i_types::mem_w);
        retire("sub sw");
        store(base + ($urandom % 4), $urandom, rv32i_types::mem_b);
        retire("sub sb");
        store(base + 2 * ($urandom % 2), $urandom, rv32i_types::mem_h);
        retire("sub sh");
        load(pipe_types::lw_wb, base);
        retire("sub lw");
        for (int off = 0; off < 4; off++) begin
            load(pipe_types::lb_wb, base + off);
            retire($sformatf("lb offset %0d", off));
            load(pipe_types::lbu_wb, base + off);
            retire($sformatf("lbu offset %0d", off));
        end
        for (int off = 0; off < 4; off += 2) begin
            load(pipe_types::lh_wb, base + off);
            retire($sformatf("lh offset %0d", off));
            load(pipe_types::lhu_wb, base + off);
            retire($sformatf("lhu offset %0d", off));
        end
        idle();
        retire("sub idle");
        report_test("sub_word", start);
    endtask

    task automatic test_misaligned();
        int                 start = err_count;
        rv32i_types::word_t base;
        base = rand_addr(4);
        store(base, $urandom, rv32i_types::mem_w);
        retire("mis setup sw");
        store(base + 1, $urandom, rv32i_types::mem_h);
        retire("mis sh offset 1");
        store(base + 2, $urandom, rv32i_types::mem_w);
        retire("mis sw offset 2");
        load(pipe_types::lw_wb, base + 3);
        retire("mis lw offset 3");
        load(pipe_types::lhu_wb, base + 1);
        retire("mis lhu offset 1");
        load(pipe_types::lw_wb, base); // Memory must still hold the first word.
        retire("lw after misaligned");
        idle();
        retire("mis idle");
        report_test("misaligned", start);
    endtask

    task automatic test_back_to_back();
        int                 start = err_count;
        int                 kind;
        rv32i_types::word_t pool [4];
        for (int i = 0; i < 4; i++) begin
            pool[i] = rand_addr(4);
            store(pool[i], $urandom, rv32i_types::mem_w);
            retire("stream fill");
        end
        for (int i = 0; i < 32; i++) begin
            kind = $urandom % 3;
            if (kind == 0) begin
                non_mem(rand_rd());
            end else if (kind == 1) begin
                store(pool[2'($urandom)] + ($urandom % 4), $urandom,
                      rv32i_types::mem_funct3_t'($urandom % 3));
            end else begin
                load(pipe_types::wb_sel_t'(4 + $urandom % 5), pool[2'($urandom)] + ($urandom % 4));
            end
            retire("stream");
        end
        idle();
        retire("stream idle");
        report_test("back_to_back", start);
    endtask

    task automatic test_reset();
        int start = err_count;
        for (int i = 0; i < 3; i++) begin
            non_mem(rand_rd());
            retire("pre-reset");
        end
        load(pipe_types::lh_wb, rand_addr(4) + 1); // Leaves the misaligned flag high.
        retire("pre-reset misaligned");
        non_mem(rand_rd()); // Still on the inputs while reset is applied.
        arst_n = 1'b0;
        #1;
        check_reset_outputs("reset asserted");
        next_cycle();
        check_reset_outputs("reset held");
        next_cycle();
        arst_n = 1'b1;
        check_reset_outputs("reset released");
        idle();
        retire("post-reset idle");
        report_test("reset", start);
    endtask

    initial begin
        void'($urandom(32'hef4a));
        arst_n     = 1'b0;
        in_pc      = '0;
        in_order   = '0;
        in_rd_s    = '0;
        in_regf_we = 1'b0;
        in_wb_sel  = pipe_types::alu_out_wb;
        in_alu_out = '0;
        in_br_en   = '0;
        in_u_imm   = '0;
        in_rs2_v   = '0;
        in_funct3  = rv32i_types::mem_w;
        exp_order  = {$urandom, $urandom};
        idle();
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_non_mem();
        test_word_store_load();
        test_sub_word();
        test_misaligned();
        test_back_to_back();
        test_reset();
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 check_count, err_count, UUT.u_assertions.fail_count);
        if (err_count == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/rv32i_types.sv
verilog/pipe_types.sv
verilog/mem_stage.sv
verilog/data_mem.sv
verilog/load_align.sv
verilog/wb_stage.sv
verilog/mem_wb_top.sv
verification/mem_wb_assertions.sv
verification/mem_wb_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module mem_wb_tb

run: build
	./obj_dir/Vmem_wb_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed."; exit 1; fi
	@grep -q "No errors" sim.log || (echo "Simulation did not complete."; exit 1)

lint:
	verilator --lint-only --timing -f project.f --top-module mem_wb_tb

clean:
	rm -rf obj_dir sim.log
